// ==== servo_subsys.f ====
+incdir+hdl
hdl/servo_pkg.sv
hdl/servo_regs.sv
hdl/servo_ramp.sv
hdl/servo_pwm.sv
hdl/servo_subsys_top.sv
verif/servo_subsys_assert.sv
verif/servo_subsys_tb.sv

// ==== verif/servo_subsys_tb.sv ====
/*
 * Arm servo subsystem testbench with clock, reset, host bus tasks,
 * reference model, pulse compare process and watchdog
 */
`timescale 1ns/1ns
`include "servo_defs.svh"

module servo_subsys_tb;

    localparam int CLK_PERIOD    = 20;                          // ns
    localparam int PERIOD_CYCLES = 256 * `SERVO_TICK_DIV;       // Clocks per PWM period
    localparam int TEST_PERIODS  = 2 * 10 + 2 * 30;             // Direct plus ramp tests
    localparam int WATCHDOG_NS   = (TEST_PERIODS + 8) * PERIOD_CYCLES * CLK_PERIOD;

    logic                   clock;
    logic                   reset_n;
    servo_pkg::addr_t       address;
    logic                   write_en;
    servo_pkg::data_t       wr_data;
    logic                   read_en;
    servo_pkg::chan_mask_t  fault;
    servo_pkg::data_t       rd_data;
    servo_pkg::chan_mask_t  servo_pwm;
    logic                   status_fault;
    logic                   status_pi;
    logic                   status_ps4;
    logic                   status_debug;

    integer                 seed;                               // $random state
    servo_pkg::data_t       model_regs [64];                    // Expected register map
    servo_pkg::ratio_t      exp_q [`SERVO_CHANNELS][$];         // Expected ratios per pulse
    int                     high_len [`SERVO_CHANNELS];         // Cycles high so far

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    servo_subsys_top uut (
        .clock          (clock),
        .reset_n        (reset_n),
        .address        (address),
        .write_en       (write_en),
        .wr_data        (wr_data),
        .read_en        (read_en),
        .rd_data        (rd_data),
        .fault          (fault),
        .servo_pwm      (servo_pwm),
        .status_fault   (status_fault),
        .status_pi      (status_pi),
        .status_ps4     (status_ps4),
        .status_debug   (status_debug)
    );

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic int ref_high_time(servo_pkg::ratio_t r);
        return int'(r) * `SERVO_TICK_DIV;                       // Ticks to clocks
    endfunction

    function automatic servo_pkg::data_t ref_read(servo_pkg::addr_t a);
        return model_regs[a];                                   // Unmapped entries stay zero
    endfunction

    function automatic void model_write(servo_pkg::addr_t a, servo_pkg::data_t d);
        if (a <= `REG_STATUS) begin
            model_regs[a] = d;                                  // Host registers only
        end
    endfunction

    function automatic servo_pkg::data_t chan_bit(int ch);
        return servo_pkg::data_t'(1) << ch;
    endfunction

    ////////////////////////////////////////
    // Error handling and compare tasks
    ////////////////////////////////////////
    task automatic abort_run(string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_data(string what, servo_pkg::data_t got, servo_pkg::data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s read 0x%02h, expected 0x%02h",
                                $time, what, got, exp));
        end
    endtask

    task automatic compare_width(int ch, servo_pkg::ratio_t r, int got);
        if (got != ref_high_time(r)) begin
            abort_run($sformatf("Mismatch at %0t ns: pwm[%0d] high %0d cycles, expected %0d",
                                $time, ch, got, ref_high_time(r)));
        end
    endtask

    task automatic compare_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // Pulse widths checked at each falling edge of a pwm bit
    always @(negedge clock) begin
        for (int ch = 0; ch < `SERVO_CHANNELS; ch++) begin
            if (servo_pwm[ch]) begin
                high_len[ch]++;
            end else if (high_len[ch] != 0) begin
                if (exp_q[ch].size() != 0) begin              // Unarmed pulses pass
                    compare_width(ch, exp_q[ch].pop_front(), high_len[ch]);
                end
                high_len[ch] = 0;
            end
        end
    end

    // Bound assertions count their failures
    always @(negedge clock) begin
        if (uut.u_assert.fail_count != 0) begin
            abort_run("An assertion in the bound checker failed");
        end
    end

    ////////////////////////////////////////
    // Host bus and timing tasks
    ////////////////////////////////////////
    task automatic host_write(servo_pkg::addr_t a, servo_pkg::data_t d);
        @(posedge clock);
        address  <= a;
        wr_data  <= d;
        write_en <= 1'b1;
        @(posedge clock);                                       // Register takes it here
        write_en <= 1'b0;
        model_write(a, d);
    endtask

    task automatic host_read_check(servo_pkg::addr_t a);
        servo_pkg::data_t got;
        @(posedge clock);
        address <= a;
        read_en <= 1'b1;
        @(posedge clock);
        read_en <= 1'b0;
        @(negedge clock);                                       // One cycle after read_en
        got = rd_data;
        compare_data($sformatf("address %0d", a), got, ref_read(a));
    endtask

    // Returns on the edge where all period counters wrap
    task automatic wait_period();
        do begin
            @(negedge clock);
        end while (!uut.period_start[0]);
        @(posedge clock);
    endtask

    task automatic wait_drained(int ch);
        while (exp_q[ch].size() != 0) begin
            @(negedge clock);
        end
    endtask

    task automatic check_low(int ch, int cycles);
        repeat (cycles) begin
            @(negedge clock);
            compare_bit($sformatf("pwm[%0d]", ch), servo_pwm[ch], 1'b0);
        end
    endtask

    // One step per period from the first latched ratio and then two held pulses
    task automatic expect_slew(int ch, servo_pkg::ratio_t from, servo_pkg::ratio_t to);
        servo_pkg::ratio_t r;
        r = from;
        wait_period();
        exp_q[ch].push_back(r);
        while (r != to) begin
            r = (r < to) ? r + 8'd1 : r - 8'd1;
            exp_q[ch].push_back(r);
        end
        repeat (2) exp_q[ch].push_back(to);
        wait_drained(ch);
    endtask

    task automatic check_leds(servo_pkg::data_t st, servo_pkg::chan_mask_t flt);
        if (st[0]) begin                                        // LED test mode
            compare_bit("status_fault", status_fault, st[3]);
            compare_bit("status_pi", status_pi, 1'b1);
            compare_bit("status_ps4", status_ps4, 1'b1);
            compare_bit("status_debug", status_debug, st[4]);
        end else begin
            compare_bit("status_fault", status_fault, |flt);
            compare_bit("status_pi", status_pi, st[1]);
            compare_bit("status_ps4", status_ps4, st[2]);
            compare_bit("status_debug", status_debug, 1'b1);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic test_registers();
        servo_pkg::addr_t a;
        for (int i = 0; i < 16; i++) begin
            a = servo_pkg::addr_t'({$random(seed)} % 7);        // Control to status
            host_write(a, servo_pkg::data_t'($random(seed)));
        end
        host_write(`REG_FAULT, servo_pkg::data_t'($random(seed)));  // Read only
        host_write(`REG_ID, servo_pkg::data_t'($random(seed)));
        for (int i = 0; i < 4; i++) begin
            a = servo_pkg::addr_t'(8 + {$random(seed)} % 55);   // Unmapped hole
            host_write(a, servo_pkg::data_t'($random(seed)));
        end
        for (int i = 0; i < 64; i++) begin
            host_read_check(servo_pkg::addr_t'(i));
        end
    endtask

    task automatic test_faults();
        servo_pkg::chan_mask_t pattern;
        servo_pkg::data_t      status;
        for (int i = 0; i < 8; i++) begin
            pattern   = servo_pkg::chan_mask_t'($random(seed));
            status    = servo_pkg::data_t'($random(seed));
            status[0] = i[0];                                   // Both LED modes
            host_write(`REG_STATUS, status);
            @(posedge clock);
            fault <= pattern;
            repeat (3) @(posedge clock);                        // Through the synchronizer
            @(negedge clock);
            check_leds(status, pattern);
            model_regs[`REG_FAULT] = servo_pkg::data_t'(pattern);
            host_read_check(`REG_FAULT);
        end
    endtask

    task automatic test_direct(int ch);
        servo_pkg::ratio_t pos;
        pos = servo_pkg::ratio_t'(8 + ({$random(seed)} % 64));
        host_write(servo_pkg::addr_t'(`REG_POS0 + ch), pos);
        host_write(`REG_RAMP_MASK, model_regs[`REG_RAMP_MASK] & ~chan_bit(ch));
        host_write(`REG_CONTROL, model_regs[`REG_CONTROL] | chan_bit(ch));
        wait_period();                                          // Ramp stage copies target
        wait_period();                                          // PWM latches it
        repeat (3) exp_q[ch].push_back(pos);
        wait_drained(ch);
        host_write(servo_pkg::addr_t'(`REG_POS0 + ch), 8'd0);
        wait_period();
        wait_period();
        check_low(ch, 2 * PERIOD_CYCLES);                       // Zero gives no pulse
    endtask

    task automatic test_ramp(int ch);
        servo_pkg::ratio_t target;
        servo_pkg::ratio_t low;
        target = servo_pkg::ratio_t'(`SERVO_START_RATIO + 3 + ({$random(seed)} % 4));
        low    = target - 8'd3;
        host_write(`REG_CONTROL, model_regs[`REG_CONTROL] & ~chan_bit(ch));
        wait_period();                                          // Parks at start ratio
        host_write(servo_pkg::addr_t'(`REG_POS0 + ch), target);
        host_write(`REG_RAMP_MASK, model_regs[`REG_RAMP_MASK] | chan_bit(ch));
        host_write(`REG_CONTROL, model_regs[`REG_CONTROL] | chan_bit(ch));
        expect_slew(ch, `SERVO_START_RATIO, target);
        host_write(servo_pkg::addr_t'(`REG_POS0 + ch), low);
        expect_slew(ch, target, low);                           // Walks back down
        // Disable in the middle of a pulse
        do begin
            @(negedge clock);
        end while (!servo_pwm[ch]);
        host_write(`REG_CONTROL, model_regs[`REG_CONTROL] & ~chan_bit(ch));
        @(posedge clock);
        @(negedge clock);
        compare_bit($sformatf("pwm[%0d] after disable", ch), servo_pwm[ch], 1'b0);
        check_low(ch, 2 * PERIOD_CYCLES);
        host_write(`REG_CONTROL, model_regs[`REG_CONTROL] | chan_bit(ch));
        expect_slew(ch, `SERVO_START_RATIO, low);               // Starts over
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        seed     = 32'h866d138b;
        reset_n  = 1'b0;
        address  = '0;
        write_en = 1'b0;
        wr_data  = '0;
        read_en  = 1'b0;
        fault    = '0;
        for (int a = 0; a < 64; a++) begin
            model_regs[a] = '0;
        end
        model_regs[`REG_ID] = `SERVO_ID;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        compare_data("rd_data after reset", rd_data, '0);
        check_leds('0, '0);                                     // Debug LED alone is lit
        for (int ch = 0; ch < `SERVO_CHANNELS; ch++) begin
            compare_bit($sformatf("pwm[%0d] after reset", ch), servo_pwm[ch], 1'b0);
        end
        test_registers();
        test_faults();
        host_write(`REG_CONTROL, 8'h00);
        host_write(`REG_RAMP_MASK, 8'h00);
        host_write(`REG_STATUS, 8'h00);
        test_direct(1);
        test_direct(3);
        test_ramp(0);
        test_ramp(2);
        if (uut.u_assert.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS));
    end

endmodule

// ==== verif/servo_subsys_assert.sv ====
/*
 * Concurrent checks on the host strobe bus and the servo PWM outputs
 * Bound to the subsystem top level
 */
`timescale 1ns/1ns
`include "servo_defs.svh"

module servo_subsys_assert (
    input  logic                    clock,          // Main clock
    input  logic                    reset_n,        // Async reset, active low
    input  logic                    write_en,       // Host write strobe
    input  logic                    read_en,        // Host read strobe
    input  servo_pkg::data_t        rd_data,        // Host read data
    input  servo_pkg::chan_mask_t   chan_enable,    // Per-servo enable
    input  servo_pkg::chan_mask_t   servo_pwm,      // Servo PWM waves
    input  servo_pkg::chan_mask_t   period_start    // Period wrap per channel
);

    int fail_count = 0;                             // Failed assertions so far

    ////////////////////////////////////////
    // Host bus
    ////////////////////////////////////////
    a_strobes_exclusive: assert property (
        @(posedge clock) disable iff (!reset_n) !(write_en && read_en)
    ) else begin
        $error("write_en and read_en are high in the same cycle");
        fail_count++;
    end

    // Read data only in the cycle after a strobe
    a_rd_data_idle: assert property (
        @(posedge clock) disable iff (!reset_n) !$past(read_en) |-> rd_data == '0
    ) else begin
        $error("rd_data is not zero without a read strobe");
        fail_count++;
    end

    ////////////////////////////////////////
    // Servo channels
    ////////////////////////////////////////
    for (genvar i = 0; i < `SERVO_CHANNELS; i++) begin : g_chan
        a_pwm_off: assert property (
            @(posedge clock) disable iff (!reset_n) !chan_enable[i] |=> !servo_pwm[i]
        ) else begin
            $error("pwm of channel %0d stays high after its enable dropped", i);
            fail_count++;
        end

        a_single_start: assert property (
            @(posedge clock) disable iff (!reset_n) period_start[i] |=> !period_start[i]
        ) else begin
            $error("period_start of channel %0d lasts two cycles", i);
            fail_count++;
        end
    end

endmodule

bind servo_subsys_top servo_subsys_assert u_assert (
    .clock          (clock),
    .reset_n        (reset_n),
    .write_en       (write_en),
    .read_en        (read_en),
    .rd_data        (rd_data),
    .chan_enable    (chan_enable),
    .servo_pwm      (servo_pwm),
    .period_start   (period_start)
);

// ==== hdl/servo_subsys_top.sv ====
/*
 * Arm servo subsystem top level
 * Register file feeding four ramp and PWM channel pairs
 */
`timescale 1ns/1ns
`include "servo_defs.svh"

module servo_subsys_top (
    input  logic                    clock,          // Main clock
    input  logic                    reset_n,        // Async reset, active low

    // Host register bus
    input  servo_pkg::addr_t        address,        // Read / write address
    input  logic                    write_en,       // Write strobe
    input  servo_pkg::data_t        wr_data,        // Write data
    input  logic                    read_en,        // Read strobe
    output servo_pkg::data_t        rd_data,        // Read data

    // Motors and servos
    input  servo_pkg::chan_mask_t   fault,          // Rotation-motor faults
    output servo_pkg::chan_mask_t   servo_pwm,      // Servo PWM waves

    // Status LEDs
    output logic                    status_fault,   // Fault seen
    output logic                    status_pi,      // Orange Pi connected
    output logic                    status_ps4,     // PS4 controller connected
    output logic                    status_debug    // General debug
);

    servo_pkg::chan_mask_t  chan_enable;                // Per-servo enable
    servo_pkg::chan_mask_t  ramp_mask;                  // Per-servo ramp select
    servo_pkg::chan_mask_t  period_start;               // Period wrap per channel
    servo_pkg::ratio_t      position [`SERVO_CHANNELS]; // Targets from host
    servo_pkg::ratio_t      ratio    [`SERVO_CHANNELS]; // Ramp to PWM

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////
    servo_regs u_regs (
        .clock          (clock),
        .reset_n        (reset_n),
        .address        (address),
        .write_en       (write_en),
        .wr_data        (wr_data),
        .read_en        (read_en),
        .fault          (fault),
        .rd_data        (rd_data),
        .chan_enable    (chan_enable),
        .ramp_mask      (ramp_mask),
        .position0      (position[0]),              // Base
        .position1      (position[1]),              // Wrist
        .position2      (position[2]),              // Centre
        .position3      (position[3]),              // Grabber
        .status_fault   (status_fault),
        .status_pi      (status_pi),
        .status_ps4     (status_ps4),
        .status_debug   (status_debug)
    );

    ////////////////////////////////////////
    // Servo channels
    ////////////////////////////////////////
    for (genvar i = 0; i < `SERVO_CHANNELS; i++) begin : g_chan

        servo_ramp u_ramp (
            .clock          (clock),
            .reset_n        (reset_n),
            .enable         (chan_enable[i]),
            .ramp           (ramp_mask[i]),
            .target         (position[i]),
            .period_start   (period_start[i]),      // From this channel's PWM
            .ratio          (ratio[i])
        );

        servo_pwm u_pwm (
            .clock          (clock),
            .reset_n        (reset_n),
            .enable         (chan_enable[i]),
            .ratio          (ratio[i]),
            .period_start   (period_start[i]),
            .pwm            (servo_pwm[i])
        );

    end

endmodule

// ==== hdl/servo_pwm.sv ====
/*
 * Tick prescaler, 8-bit period counter and registered PWM output
 */
`timescale 1ns/1ns
`include "servo_defs.svh"

module servo_pwm (
    input  logic                clock,          // Main clock
    input  logic                reset_n,        // Async reset, active low
    input  logic                enable,         // Channel enable
    input  servo_pkg::ratio_t   ratio,          // High time from the ramp
    output logic                period_start,   // Pulse at period wrap
    output logic                pwm             // Servo drive
);

    localparam int TICK_W = $clog2(`SERVO_TICK_DIV);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`SERVO_TICK_DIV - 1);

    logic [TICK_W-1:0]  tick_cnt;               // Prescaler
    logic               tick_last;              // Last clock of a tick
    servo_pkg::ratio_t  period_cnt;             // Ticks into the period
    servo_pkg::ratio_t  period_next;            // Count after this clock
    servo_pkg::ratio_t  ratio_lat;              // Ratio for this period
    servo_pkg::ratio_t  ratio_next;             // Ratio after this clock

    ////////////////////////////////////////
    // Prescaler and period counter
    ////////////////////////////////////////
    assign tick_last    = tick_cnt == TICK_LAST;
    assign period_start = tick_last && (period_cnt == '1);  // Counter wraps here

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            tick_cnt <= '0;
        end else if (tick_last) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Free running so all channels stay aligned
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_next;
        end
    end

    assign period_next = tick_last ? period_cnt + 1'b1 : period_cnt;   // Wraps at 255

    ////////////////////////////////////////
    // Ratio latch
    ////////////////////////////////////////
    assign ratio_next = period_start ? ratio : ratio_lat;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ratio_lat <= '0;
        end else begin
            ratio_lat <= ratio_next;            // Held for a whole period
        end
    end

    ////////////////////////////////////////
    // Output compare
    ////////////////////////////////////////
    // Compare on next-state values so the flop lines up with the count
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pwm <= 1'b0;
        end else begin
            pwm <= enable && (period_next < ratio_next);    // Low when disabled
        end
    end

endmodule

// ==== hdl/servo_ramp.sv ====
/*
 * Per-channel ratio slew toward the target position
 */
`timescale 1ns/1ns
`include "servo_defs.svh"

module servo_ramp (
    input  logic                clock,          // Main clock
    input  logic                reset_n,        // Async reset, active low
    input  logic                enable,         // Channel enable
    input  logic                ramp,           // Slew instead of jump
    input  servo_pkg::ratio_t   target,         // Target position
    input  logic                period_start,   // One pulse per PWM period
    output servo_pkg::ratio_t   ratio           // Current high time to PWM
);

    servo_pkg::ratio_t  ratio_q;                // Current ratio
    servo_pkg::ratio_t  ratio_step;             // Ratio after one slew step
    logic               below;                  // Still under target
    logic               above;                  // Still over target

    ////////////////////////////////////////
    // Slew step
    ////////////////////////////////////////
    assign below = ratio_q < target;
    assign above = ratio_q > target;

    always_comb begin
        if (below) begin
            ratio_step = ratio_q + 1'b1;        // Climb one tick
        end else if (above) begin
            ratio_step = ratio_q - 1'b1;        // Drop one tick
        end else begin
            ratio_step = ratio_q;               // Arrived, hold
        end
    end

    ////////////////////////////////////////
    // Ratio register
    ////////////////////////////////////////
    // Only moves at a period boundary, so every pulse sees one value
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ratio_q <= `SERVO_START_RATIO;
        end else if (period_start) begin
            if (!enable) begin
                ratio_q <= `SERVO_START_RATIO;  // Park for next enable
            end else if (!ramp) begin
                ratio_q <= target;              // Direct servo
            end else begin
                ratio_q <= ratio_step;          // Ramped servo
            end
        end
    end

    assign ratio = ratio_q;

endmodule

// ==== hdl/servo_regs.sv ====
/*
 * Host register file with address decode and read mux
 * Fault input synchronizer and status LED selection
 */
`timescale 1ns/1ns
`include "servo_defs.svh"

module servo_regs (
    input  logic                    clock,          // Main clock
    input  logic                    reset_n,        // Async reset, active low
    input  servo_pkg::addr_t        address,        // Read / write address
    input  logic                    write_en,       // Write strobe
    input  servo_pkg::data_t        wr_data,        // Write data
    input  logic                    read_en,        // Read strobe
    input  servo_pkg::chan_mask_t   fault,          // Raw rotation-motor faults
    output servo_pkg::data_t        rd_data,        // Read data, one cycle late
    output servo_pkg::chan_mask_t   chan_enable,    // Servo enables
    output servo_pkg::chan_mask_t   ramp_mask,      // Servo ramp select
    output servo_pkg::ratio_t       position0,      // Base target
    output servo_pkg::ratio_t       position1,      // Wrist target
    output servo_pkg::ratio_t       position2,      // Centre target
    output servo_pkg::ratio_t       position3,      // Grabber target
    output logic                    status_fault,   // Fault LED
    output logic                    status_pi,      // Orange Pi LED
    output logic                    status_ps4,     // PS4 LED
    output logic                    status_debug    // Debug LED
);

    servo_pkg::data_t       control_reg;                // Enables in low bits
    servo_pkg::data_t       ramp_reg;                   // Ramp select in low bits
    servo_pkg::data_t       pos_reg [`SERVO_CHANNELS];  // Target positions
    servo_pkg::data_t       status_reg;                 // LED control bits
    servo_pkg::chan_mask_t  fault_meta;                 // First sync stage
    servo_pkg::chan_mask_t  fault_sync;                 // Second sync stage
    servo_pkg::data_t       read_value;                 // Addressed value

    logic                   led_test;                   // LED test mode
    logic                   pi_led;                     // Pi connected
    logic                   ps4_led;                    // PS4 connected
    logic                   fault_led;                  // Fault LED in test mode
    logic                   motor_hot;                  // Debug LED in test mode

    ////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            control_reg <= '0;
            ramp_reg    <= '0;
            status_reg  <= '0;
            for (int i = 0; i < `SERVO_CHANNELS; i++) begin
                pos_reg[i] <= '0;
            end
        end else if (write_en) begin
            case (address)
                `REG_CONTROL:   control_reg <= wr_data;
                `REG_RAMP_MASK: ramp_reg    <= wr_data;
                `REG_POS0:      pos_reg[0]  <= wr_data;
                `REG_POS1:      pos_reg[1]  <= wr_data;
                `REG_POS2:      pos_reg[2]  <= wr_data;
                `REG_POS3:      pos_reg[3]  <= wr_data;
                `REG_STATUS:    status_reg  <= wr_data;
                default: ;                                  // Read-only or unmapped
            endcase
        end
    end

    ////////////////////////////////////////
    // Fault synchronizer
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fault_meta <= '0;
            fault_sync <= '0;
        end else begin
            fault_meta <= fault;                            // May go metastable
            fault_sync <= fault_meta;                       // Safe to use
        end
    end

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////
    always_comb begin
        case (address)
            `REG_CONTROL:   read_value = control_reg;
            `REG_RAMP_MASK: read_value = ramp_reg;
            `REG_POS0:      read_value = pos_reg[0];
            `REG_POS1:      read_value = pos_reg[1];
            `REG_POS2:      read_value = pos_reg[2];
            `REG_POS3:      read_value = pos_reg[3];
            `REG_STATUS:    read_value = status_reg;
            `REG_FAULT:     read_value = servo_pkg::data_t'(fault_sync);  // Zero extended
            `REG_ID:        read_value = `SERVO_ID;
            default:        read_value = '0;                // Unmapped reads zero
        endcase
    end

    // Data is valid only in the cycle after the strobe
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_data <= '0;
        end else begin
            rd_data <= read_en ? read_value : '0;
        end
    end

    ////////////////////////////////////////
    // Channel controls
    ////////////////////////////////////////
    assign chan_enable = control_reg[`SERVO_CHANNELS-1:0];  // One enable per servo
    assign ramp_mask   = ramp_reg[`SERVO_CHANNELS-1:0];     // One ramp bit per servo
    assign position0   = pos_reg[0];
    assign position1   = pos_reg[1];
    assign position2   = pos_reg[2];
    assign position3   = pos_reg[3];

    ////////////////////////////////////////
    // Status LEDs
    ////////////////////////////////////////
    assign led_test  = status_reg[0];                       // Overrides all LEDs
    assign pi_led    = status_reg[1];
    assign ps4_led   = status_reg[2];
    assign fault_led = status_reg[3];
    assign motor_hot = status_reg[4];

    assign status_fault = led_test ? fault_led : |fault_sync;   // Any motor fault
    assign status_pi    = led_test ? 1'b1      : pi_led;
    assign status_ps4   = led_test ? 1'b1      : ps4_led;
    assign status_debug = led_test ? motor_hot : 1'b1;          // Alive indicator

endmodule

// ==== hdl/servo_pkg.sv ====
/*
 * Shared vector types of the arm servo subsystem
 */
`include "servo_defs.svh"

package servo_pkg;

    ////////////////////////////////////////
    // Host bus
    ////////////////////////////////////////

    // Register address on the strobe bus
    typedef logic [`SERVO_ADDR_W-1:0]   addr_t;

    // Register read and write data
    typedef logic [`SERVO_DATA_W-1:0]   data_t;

    ////////////////////////////////////////
    // Servo datapath
    ////////////////////////////////////////

    // PWM high time in ticks, also the period count
    typedef logic [`SERVO_RATIO_W-1:0]  ratio_t;

    // One bit per servo channel
    typedef logic [`SERVO_CHANNELS-1:0] chan_mask_t;

endpackage

// ==== hdl/servo_defs.svh ====
/*
 * Widths, channel count, PWM tick divider and start ratio
 * Host register map and identification value
 */
`ifndef SERVO_DEFS_SVH
`define SERVO_DEFS_SVH

// Bus and datapath widths
`define SERVO_ADDR_W        6           // Host address width
`define SERVO_DATA_W        8           // Host data width
`define SERVO_RATIO_W       8           // PWM high time, ticks out of 256
`define SERVO_CHANNELS      4           // Arm servos

// Timing base
`define SERVO_TICK_DIV      4           // Clocks per PWM tick, small for sim
`define SERVO_START_RATIO   8'd5        // Where a ramped servo begins
`define SERVO_ID            8'hA5       // Read-only identification

// Register map
`define REG_CONTROL         6'd0        // Channel enables
`define REG_RAMP_MASK       6'd1        // Per-channel ramp select
`define REG_POS0            6'd2        // Base servo target
`define REG_POS1            6'd3        // Wrist servo target
`define REG_POS2            6'd4        // Centre servo target
`define REG_POS3            6'd5        // Grabber servo target
`define REG_STATUS          6'd6        // LED control bits
`define REG_FAULT           6'd7        // Synced faults, read only
`define REG_ID              6'd63       // ID value, read only

`endif
